//--- hw/nfcPkg.sv
`default_nettype none

package nfcPkg;

    // command/address word, sent as bytes msb first
    localparam int caWidth    = 40;
    localparam int byteWidth  = 8;
    localparam int maxBytes   = caWidth / byteWidth;  // 5
    localparam int countWidth = 4;                    // numOfData, count minus one

    // DQ carries each byte on every lane
    localparam int dqLanes = 4;
    localparam int dqWidth = dqLanes * byteWidth;

    // two dies per way share one strobe copy each
    localparam int latchPins = 2;

    // bus timing in system clock cycles
    localparam int setupCycles  = 10;  // latch enable rise to first byte
    localparam int byteCycles   = 10;
    localparam int weHighCycles = 5;   // WE high at the head of a byte
    localparam int timerWidth   = 4;

    typedef logic [byteWidth-1:0] caByte_t;
    typedef logic [caWidth-1:0]   caWord_t;
    typedef logic [dqWidth-1:0]   dqWord_t;

endpackage

`default_nettype wire

//--- hw/commandSequencer.sv
`default_nettype none

module commandSequencer import nfcPkg::*; (
    input  wire  iSystemClock,
    input  wire  arstN,
    input  wire  start,
    input  wire  lastByte,
    output logic ready,
    output logic lastStep,
    output logic capture,
    output logic busActive,
    output logic byteValid,
    output logic weWindow,
    output logic byteAdvance
);

    // finish: one cycle with the pins dropped, one with lastStep up
    localparam int finishCycles = 2;

    localparam logic [2:0] phaseIdle   = 3'd0;
    localparam logic [2:0] phaseReady  = 3'd1;
    localparam logic [2:0] phaseSetup  = 3'd2;
    localparam logic [2:0] phaseByte   = 3'd3;
    localparam logic [2:0] phaseFinish = 3'd4;

    logic [2:0]            phase;
    logic [2:0]            phaseNext;
    logic [timerWidth-1:0] timer;
    logic                  timerDone;

    // ready is only ever high while sitting in the ready phase
    assign capture = start & ready;

    assign busActive   = (phase == phaseSetup) || (phase == phaseByte);
    assign byteValid   = phase == phaseByte;
    assign weWindow    = byteValid && (timer < timerWidth'(weHighCycles));
    assign byteAdvance = byteValid && (timer == timerWidth'(byteCycles - 1));

    always_comb begin
        case (phase)
            phaseSetup: begin
                timerDone = timer == timerWidth'(setupCycles - 1);
            end
            phaseByte: begin
                timerDone = byteAdvance;
            end
            phaseFinish: begin
                timerDone = timer == timerWidth'(finishCycles - 1);
            end
            default: begin
                timerDone = 1'b1;  // keeps the timer parked at zero
            end
        endcase
    end

    always_comb begin
        phaseNext = phase;
        case (phase)
            phaseIdle: begin
                phaseNext = phaseReady;
            end
            phaseReady: begin
                phaseNext = capture ? phaseSetup : phaseReady;
            end
            phaseSetup: begin
                phaseNext = timerDone ? phaseByte : phaseSetup;
            end
            phaseByte: begin
                // another byte unless the queue says this was the last
                phaseNext = (timerDone && lastByte) ? phaseFinish : phaseByte;
            end
            phaseFinish: begin
                phaseNext = timerDone ? phaseReady : phaseFinish;
            end
            default: begin
                phaseNext = phaseIdle;
            end
        endcase
    end

    always_ff @(posedge iSystemClock or negedge arstN) begin
        if (!arstN) begin
            phase    <= phaseIdle;
            timer    <= '0;
            ready    <= 1'b0;
            lastStep <= 1'b0;
        end else begin
            phase    <= phaseNext;
            timer    <= timerDone ? '0 : timer + 1'b1;
            ready    <= phaseNext == phaseReady;
            lastStep <= (phase == phaseFinish) && (timer == '0);  // lands with pins low
        end
    end

endmodule

`default_nettype wire

//--- hw/caByteQueue.sv
`default_nettype none

module caByteQueue import nfcPkg::*; (
    input  wire                  iSystemClock,
    input  wire                  arstN,
    input  wire                  capture,
    input  wire                  byteAdvance,
    input  wire caWord_t         caData,
    input  wire [countWidth-1:0] numOfData,
    output caByte_t              currentByte,
    output logic                 lastByte
);

    localparam logic [countWidth-1:0] lastIndex = countWidth'(maxBytes - 1);

    caWord_t               word;
    logic [countWidth-1:0] remaining;  // bytes still to come after the current one
    logic [countWidth-1:0] loadCount;

    // anything past the word length sends the whole word
    assign loadCount = (numOfData > lastIndex) ? lastIndex : numOfData;

    assign currentByte = word[caWidth-1 -: byteWidth];

    always_ff @(posedge iSystemClock) begin
        if (capture) begin
            word <= caData;
        end else if (byteAdvance) begin
            word <= {word[caWidth-byteWidth-1:0], {byteWidth{1'b0}}};  // next byte to the top
        end
    end

    always_ff @(posedge iSystemClock or negedge arstN) begin
        if (!arstN) begin
            remaining <= '0;
            lastByte  <= 1'b0;
        end else if (capture) begin
            remaining <= loadCount;
            lastByte  <= loadCount == '0;
        end else if (byteAdvance && (remaining != '0)) begin
            remaining <= remaining - 1'b1;
            lastByte  <= remaining == countWidth'(1);
        end
    end

endmodule

`default_nettype wire

//--- hw/nandPinDriver.sv
`default_nettype none

module nandPinDriver import nfcPkg::*; #(
    parameter int numberOfWays = 4
) (
    input  wire                        iSystemClock,
    input  wire                        arstN,
    input  wire                        capture,
    input  wire [numberOfWays-1:0]     targetWay,
    input  wire                        caSelect,
    input  wire                        busActive,
    input  wire                        byteValid,
    input  wire                        weWindow,
    input  wire caByte_t               currentByte,
    output logic [2*numberOfWays-1:0]  chipEnable,
    output logic [latchPins-1:0]       writeEnable,
    output logic [latchPins-1:0]       addressLatchEnable,
    output logic [latchPins-1:0]       commandLatchEnable,
    output dqWord_t                    dq
);

    logic [numberOfWays-1:0] wayHeld;
    logic                    commandHeld;  // 1 for command, 0 for address

    // request fields held for the whole transfer
    always_ff @(posedge iSystemClock) begin
        if (capture) begin
            wayHeld     <= targetWay;
            commandHeld <= caSelect;
        end
    end

    always_ff @(posedge iSystemClock or negedge arstN) begin
        if (!arstN) begin
            chipEnable         <= '0;
            writeEnable        <= '0;
            addressLatchEnable <= '0;
            commandLatchEnable <= '0;
            dq                 <= '0;
        end else begin
            chipEnable         <= busActive ? {2{wayHeld}} : '0;  // same mask for both dies
            commandLatchEnable <= {latchPins{busActive & commandHeld}};
            addressLatchEnable <= {latchPins{busActive & ~commandHeld}};
            writeEnable        <= {latchPins{weWindow}};
            dq                 <= byteValid ? {dqLanes{currentByte}} : '0;
        end
    end

endmodule

`default_nettype wire

//--- hw/nfcCommandAsync.sv
`default_nettype none

module nfcCommandAsync import nfcPkg::*; #(
    parameter int numberOfWays = 4
) (
    input  wire                        iSystemClock,
    input  wire                        arstN,
    input  wire                        start,
    input  wire [numberOfWays-1:0]     targetWay,
    input  wire [countWidth-1:0]       numOfData,
    input  wire                        caSelect,
    input  wire caWord_t               caData,
    output logic                       ready,
    output logic                       lastStep,
    output dqWord_t                    dq,
    output logic [2*numberOfWays-1:0]  chipEnable,
    output logic [latchPins-1:0]       writeEnable,
    output logic [latchPins-1:0]       addressLatchEnable,
    output logic [latchPins-1:0]       commandLatchEnable
);

    logic    capture;
    logic    busActive;
    logic    byteValid;
    logic    weWindow;
    logic    byteAdvance;
    logic    lastByte;
    caByte_t currentByte;

    commandSequencer u_commandSequencer (
        .iSystemClock (iSystemClock),
        .arstN        (arstN),
        .start        (start),
        .lastByte     (lastByte),
        .ready        (ready),
        .lastStep     (lastStep),
        .capture      (capture),
        .busActive    (busActive),
        .byteValid    (byteValid),
        .weWindow     (weWindow),
        .byteAdvance  (byteAdvance)
    );

    caByteQueue u_caByteQueue (
        .iSystemClock (iSystemClock),
        .arstN        (arstN),
        .capture      (capture),
        .byteAdvance  (byteAdvance),
        .caData       (caData),
        .numOfData    (numOfData),
        .currentByte  (currentByte),
        .lastByte     (lastByte)
    );

    nandPinDriver #(
        .numberOfWays (numberOfWays)
    ) u_nandPinDriver (
        .iSystemClock       (iSystemClock),
        .arstN              (arstN),
        .capture            (capture),
        .targetWay          (targetWay),
        .caSelect           (caSelect),
        .busActive          (busActive),
        .byteValid          (byteValid),
        .weWindow           (weWindow),
        .currentByte        (currentByte),
        .chipEnable         (chipEnable),
        .writeEnable        (writeEnable),
        .addressLatchEnable (addressLatchEnable),
        .commandLatchEnable (commandLatchEnable),
        .dq                 (dq)
    );

endmodule

`default_nettype wire

//--- bench/nfcCommandAsync_assert.sv
`default_nettype none

module nfcCommandAsyncAssert import nfcPkg::*; #(
    parameter int numberOfWays = 4
) (
    input wire                       iSystemClock,
    input wire                       arstN,
    input wire                       ready,
    input wire                       lastStep,
    input wire [2*numberOfWays-1:0]  chipEnable,
    input wire [latchPins-1:0]       writeEnable,
    input wire [latchPins-1:0]       addressLatchEnable,
    input wire [latchPins-1:0]       commandLatchEnable
);
    timeunit 1ns;
    timeprecision 1ps;

    readyApartFromLast: assert property (@(posedge iSystemClock) disable iff (!arstN)
        !(ready && lastStep))
        else $error("ready and lastStep are high together");

    // one latch type per transfer, held while the chip stays enabled
    latchSteady: assert property (@(posedge iSystemClock) disable iff (!arstN)
        ((|chipEnable) && $past(|chipEnable)) |->
            ($stable(addressLatchEnable) && $stable(commandLatchEnable)))
        else $error("a latch enable changed in the middle of a transfer");

    writeNeedsChip: assert property (@(posedge iSystemClock) disable iff (!arstN)
        (|writeEnable) |-> (|chipEnable))
        else $error("writeEnable is high with no chip enabled");

    lastStepPulse: assert property (@(posedge iSystemClock) disable iff (!arstN)
        lastStep |=> !lastStep)
        else $error("lastStep is high for more than one cycle");

endmodule

bind nfcCommandAsync nfcCommandAsyncAssert #(
    .numberOfWays (numberOfWays)
) u_nfcCommandAsyncAssert (
    .iSystemClock       (iSystemClock),
    .arstN              (arstN),
    .ready              (ready),
    .lastStep           (lastStep),
    .chipEnable         (chipEnable),
    .writeEnable        (writeEnable),
    .addressLatchEnable (addressLatchEnable),
    .commandLatchEnable (commandLatchEnable)
);

`default_nettype wire

//--- bench/nfcCommandAsyncTb.sv
`default_nettype none

module nfcCommandAsyncTb import nfcPkg::*; ();
    timeunit 1ns;
    timeprecision 1ps;

    localparam int numberOfWays      = 4;
    localparam int clockPeriod       = 8;
    localparam int resetCycles       = 16;
    localparam int transfers         = 20;
    localparam int cyclesPerTransfer = 64;  // five bytes plus gaps
    localparam int cycleLimit        = resetCycles + transfers * cyclesPerTransfer + 100;
    localparam int readyLimit        = 100;

    typedef logic [2*numberOfWays-1:0] pinVector_t;
    localparam pinVector_t latchHigh = pinVector_t'({latchPins{1'b1}});

    logic                       iSystemClock;
    logic                       arstN;
    logic                       start;
    logic [numberOfWays-1:0]    targetWay;
    logic [countWidth-1:0]      numOfData;
    logic                       caSelect;
    caWord_t                    caData;
    logic                       ready;
    logic                       lastStep;
    dqWord_t                    dq;
    logic [2*numberOfWays-1:0]  chipEnable;
    logic [latchPins-1:0]       writeEnable;
    logic [latchPins-1:0]       addressLatchEnable;
    logic [latchPins-1:0]       commandLatchEnable;
    int                         cycleCount = 0;

    nfcCommandAsync #(
        .numberOfWays (numberOfWays)
    ) u_nfcCommandAsync (
        .iSystemClock       (iSystemClock),
        .arstN              (arstN),
        .start              (start),
        .targetWay          (targetWay),
        .numOfData          (numOfData),
        .caSelect           (caSelect),
        .caData             (caData),
        .ready              (ready),
        .lastStep           (lastStep),
        .dq                 (dq),
        .chipEnable         (chipEnable),
        .writeEnable        (writeEnable),
        .addressLatchEnable (addressLatchEnable),
        .commandLatchEnable (commandLatchEnable)
    );

    initial begin
        iSystemClock = 1'b0;
        forever #(clockPeriod / 2) iSystemClock = ~iSystemClock;
    end

    task automatic failRun(input string reason);
        $display("%s", reason);
        $display("Errors found");
        $fatal(1, "simulation stopped");
    endtask

    always @(posedge iSystemClock) begin
        if (cycleCount >= cycleLimit) failRun("timeout, the tests ran past the cycle limit");
        else cycleCount <= cycleCount + 1;
    end

    task automatic checkByte(input string name, input caByte_t actual, input caByte_t expected);
        if (actual !== expected)
            failRun($sformatf("Mismatch at %0t: %s is %h, expected %h",
                              $time, name, actual, expected));
    endtask

    task automatic checkWord(input string name, input dqWord_t actual, input dqWord_t expected);
        if (actual !== expected)
            failRun($sformatf("Mismatch at %0t: %s is %h, expected %h",
                              $time, name, actual, expected));
    endtask

    task automatic checkBit(input string name, input logic actual, input logic expected);
        if (actual !== expected)
            failRun($sformatf("Mismatch at %0t: %s is %b, expected %b",
                              $time, name, actual, expected));
    endtask

    task automatic checkPins(input string name, input pinVector_t actual,
                             input pinVector_t expected);
        if (actual !== expected)
            failRun($sformatf("Mismatch at %0t: %s is %b, expected %b",
                              $time, name, actual, expected));
    endtask

    // byte k of the word, msb first
    function automatic caByte_t byteOfWord(input caWord_t word, input int k);
        return word[caWidth-1-byteWidth*k -: byteWidth];
    endfunction

    task automatic scrambleInputs();
        targetWay = numberOfWays'($urandom);
        caSelect  = 1'($urandom);
        numOfData = countWidth'($urandom);
        caData    = caWord_t'({$urandom, $urandom});
    endtask

    task automatic waitReady();
        int waited;
        waited = 0;
        while (ready !== 1'b1) begin
            if (waited >= readyLimit) failRun("ready did not come back high");
            else begin
                @(negedge iSystemClock);
                waited++;
            end
        end
    endtask

    // one request, checked against the cycle table edge by edge
    task automatic runTransfer(
        input logic [numberOfWays-1:0] way,
        input logic                    sel,
        input caWord_t                 word,
        input logic [countWidth-1:0]   count,
        input int                      busyAt   // cycle of a stray start, 0 for none
    );
        int         byteCount;
        int         endCycle;
        int         cycle;
        int         offset;
        bit         onBus;
        bit         onByte;
        caByte_t    byteExp;
        pinVector_t latchExp;

        byteCount = (int'(count) >= maxBytes) ? maxBytes : int'(count) + 1;
        endCycle  = setupCycles + byteCycles * byteCount + 2;
        waitReady();
        start     = 1'b1;
        targetWay = way;
        caSelect  = sel;
        caData    = word;
        numOfData = count;
        @(negedge iSystemClock);
        checkBit("ready", ready, 1'b0);
        start = 1'b0;
        scrambleInputs();  // request must be held inside
        for (cycle = 1; cycle <= endCycle; cycle++) begin
            @(negedge iSystemClock);
            offset   = cycle - setupCycles - 1;
            onBus    = cycle <= setupCycles + byteCycles * byteCount;
            onByte   = onBus && (offset >= 0);
            byteExp  = onByte ? byteOfWord(word, offset / byteCycles) : '0;
            latchExp = onBus ? latchHigh : '0;
            checkBit("ready", ready, cycle == endCycle);
            checkBit("lastStep", lastStep, cycle == endCycle - 1);
            checkPins("chipEnable", chipEnable, onBus ? pinVector_t'({way, way}) : '0);
            checkPins("commandLatchEnable", pinVector_t'(commandLatchEnable),
                      sel ? latchExp : '0);
            checkPins("addressLatchEnable", pinVector_t'(addressLatchEnable),
                      sel ? '0 : latchExp);
            checkPins("writeEnable", pinVector_t'(writeEnable),
                      (onByte && (offset % byteCycles < weHighCycles)) ? latchHigh : '0);
            checkByte("dq top lane", dq[dqWidth-1 -: byteWidth], byteExp);
            checkWord("dq", dq, onByte ? {dqLanes{byteExp}} : '0);
            start = cycle == busyAt;
            if (cycle == busyAt) scrambleInputs();
        end
    endtask

    task automatic verifyReset();
        repeat (resetCycles) begin
            @(negedge iSystemClock);
            checkBit("ready", ready, 1'b0);
            checkBit("lastStep", lastStep, 1'b0);
            checkPins("chipEnable", chipEnable, '0);
            checkPins("writeEnable", pinVector_t'(writeEnable), '0);
            checkPins("addressLatchEnable", pinVector_t'(addressLatchEnable), '0);
            checkPins("commandLatchEnable", pinVector_t'(commandLatchEnable), '0);
            checkWord("dq", dq, '0);
        end
        arstN = 1'b1;
        repeat (2) @(negedge iSystemClock);
        checkBit("ready", ready, 1'b1);
        checkBit("lastStep", lastStep, 1'b0);
        checkPins("chipEnable", chipEnable, '0);
        checkPins("writeEnable", pinVector_t'(writeEnable), '0);
        checkPins("addressLatchEnable", pinVector_t'(addressLatchEnable), '0);
        checkPins("commandLatchEnable", pinVector_t'(commandLatchEnable), '0);
        checkWord("dq", dq, '0);
    endtask

    task automatic sendOneByteCommand();
        runTransfer(4'b0001, 1'b1, 40'ha5_3c_0f_96_e1, 4'd0, 0);
    endtask

    task automatic sendFiveByteAddress();
        runTransfer(4'b1010, 1'b0, 40'h12_34_56_78_9a, 4'd4, 0);
    endtask

    task automatic ignoreBusyStart();
        runTransfer(4'b0110, 1'b1, 40'hc3_5a_e7_00_ff, 4'd2, 15);
        runTransfer(4'b1000, 1'b0, 40'h0f_1e_2d_3c_4b, 4'd1, 31);  // stray start next to lastStep
    endtask

    task automatic sendClampedAndRandom();
        logic [numberOfWays-1:0] way;
        logic                    sel;
        caWord_t                 word;
        logic [countWidth-1:0]   count;

        runTransfer(4'b1111, 1'b0, 40'hde_ad_be_ef_42, 4'd9, 0);
        repeat (15) begin
            way   = numberOfWays'($urandom_range(2 ** numberOfWays - 1, 1));
            sel   = 1'($urandom);
            word  = caWord_t'({$urandom, $urandom});
            count = countWidth'($urandom);
            runTransfer(way, sel, word, count, 0);
        end
    endtask

    initial begin
        void'($urandom(32'hf547));
        arstN     = 1'b0;
        start     = 1'b0;
        targetWay = '0;
        numOfData = '0;
        caSelect  = 1'b0;
        caData    = '0;
        verifyReset();
        sendOneByteCommand();
        sendFiveByteAddress();
        ignoreBusyStart();
        sendClampedAndRandom();
        $display("No errors");
        $finish;
    end

endmodule

`default_nettype wire

//--- build.f
hw/nfcPkg.sv
hw/commandSequencer.sv
hw/caByteQueue.sv
hw/nandPinDriver.sv
hw/nfcCommandAsync.sv
bench/nfcCommandAsync_assert.sv
bench/nfcCommandAsyncTb.sv

//--- run.sh
#!/usr/bin/env bash
# build and run with Verilator, then scan the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

# a failed build or a nonzero exit also counts as a failure
verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module nfcCommandAsyncTb -f build.f -o simv > sim.log 2>&1 \
    && ./obj_dir/simv >> sim.log 2>&1 \
    || echo "Errors found" >> sim.log

cat sim.log
grep -q "Errors found" sim.log && { echo "FAIL"; exit 1; } || { echo "PASS"; exit 0; }
